// File: Bender.yml
package:
  name: ppu_bg

sources:
  - source/ppu_reg_pkg.sv
  - source/ppu_timing_pkg.sv
  - source/ppu_regs.sv
  - source/ppu_line_timer.sv
  - source/ppu_bg_fetcher.sv
  - source/ppu_pixel_shifter.sv
  - source/ppu_top.sv
  - target: test
    files:
      - bench/ppu_checker.sv
      - bench/ppu_assert.sv
      - bench/ppu_tb.sv

// File: bench/ppu_assert.sv
// ########################################
// bound to ppu_top, checks strobes and mode gating
// ########################################
module ppu_assert
    import ppu_timing_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      irq_vblank,
    input logic      px_valid,
    input logic      vram_rd,
    input ppu_mode_e mode
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // read by the testbench at the end

    a_vblank_pulse: assert property (@(posedge clk) disable iff (rst) irq_vblank |=> !irq_vblank)
        else begin
            $error("irq_vblank high for more than one cycle");
            fail_count++;
        end

    a_px_in_draw: assert property (@(posedge clk) disable iff (rst) px_valid |-> mode == mode_draw)
        else begin
            $error("px_valid outside the draw mode");
            fail_count++;
        end

    a_rd_in_draw: assert property (@(posedge clk) disable iff (rst) vram_rd |-> mode == mode_draw)
        else begin
            $error("vram_rd outside the draw mode");
            fail_count++;
        end

endmodule

bind ppu_top ppu_assert u_assert (.*);

// File: bench/ppu_checker.sv
// ########################################
// watches the PPU ports and shadows the CPU writes
// expects register writes only while the LCD is off or in V-blank
// ########################################
module ppu_checker
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t cpu_addr,
    input  logic      cpu_wr,
    input  logic      cpu_rd,
    input  reg_byte_t cpu_wdata,
    input  reg_byte_t cpu_rdata,
    input  px_t       px,
    input  logic      px_valid,
    input  logic      irq_vblank,
    input  logic      irq_lcdc,
    input  ppu_mode_e mode
);
    timeunit 1ns;
    timeprecision 1ps;

    reg_byte_t  lcdc_sh;
    reg_byte_t  scx_sh;
    reg_byte_t  scy_sh;
    reg_byte_t  lyc_sh;
    logic [3:0] ie_sh;      // STAT bits 6..3
    ppu_mode_e  prev_mode;
    logic       lcd_on;
    logic       lcd_q;
    logic       have_vb;
    logic       frame_started;
    logic       rd_pend;
    cpu_addr_t  rd_addr;
    reg_byte_t  rd_exp;
    int         cyc;
    int         off_cnt;
    int         scan_cnt;
    int         px_cnt;
    int         cur_line;   // read by the testbench
    int         scan_entry_cyc;
    int         last_scan_cyc;
    int         last_vb_cyc;
    int         lcdc_irqs;
    int         errors = 0;
    int         mark = 0;
    int         tests = 0;
    int         tests_failed = 0;

    function automatic reg_byte_t vram_byte(input logic [15:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // background pixel at screen position (x, line) from the scroll and map rules
    function automatic px_t expected_px(input int line, input int x);
        int          ybg;
        int          xbg;
        int          num;
        int          b;
        logic [15:0] map_a;
        logic [15:0] tile_a;
        reg_byte_t   lo;
        reg_byte_t   hi;
        if (!lcdc_sh[0]) return 2'b00;
        ybg   = (line + scy_sh) % 256;
        xbg   = (x + scx_sh) % 256;
        map_a = (lcdc_sh[3] ? 16'h9C00 : 16'h9800) + 16'((ybg / 8) * 32 + xbg / 8);
        if (lcdc_sh[4]) num = int'(vram_byte(map_a));
        else num = int'($signed(vram_byte(map_a))); // signed tile number
        tile_a = 16'((lcdc_sh[4] ? 32'h8000 : 32'h9000) + num * 16 + (ybg % 8) * 2);
        lo = vram_byte(tile_a);
        hi = vram_byte(tile_a + 16'd1);
        b  = 7 - xbg % 8;
        return {hi[b], lo[b]};
    endfunction

    task automatic fail_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (errors < 20) $display("FAILED %s: got %h expected %h", sig, got, exp);
        errors++;
    endtask

    task automatic fail_text(input string msg);
        if (errors < 20) $display("error: %s", msg);
        errors++;
    endtask

    task automatic expect_read(input cpu_addr_t a, input reg_byte_t e);
        rd_exp = e;
        rd_addr = a;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests, name, errors - mark);
            tests_failed++;
        end
        mark = errors;
    endtask

    task automatic summary();
        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            lcdc_sh = '0;
            scx_sh = '0;
            scy_sh = '0;
            lyc_sh = '0;
            ie_sh = '0;
            prev_mode = mode_scan;
            lcd_q = 1'b0;
            have_vb = 1'b0;
            frame_started = 1'b0;
            rd_pend = 1'b0;
            cyc = 0;
            off_cnt = 0;
            scan_cnt = 0;
            px_cnt = 0;
            cur_line = 0;
            lcdc_irqs = 0;
        end else begin
            cyc++;
            lcd_on = lcdc_sh[7];
            if (rd_pend && cpu_rdata != rd_exp)
                fail_value($sformatf("cpu_rdata at %h", rd_addr), cpu_rdata, rd_exp);
            rd_pend = cpu_rd;
            if (!lcd_on) begin
                off_cnt++;
                have_vb = 1'b0;
                frame_started = 1'b0;
                scan_cnt = 0;
                px_cnt = 0;
                cur_line = 0;
                // one cycle of slack while the timer drops out
                if (off_cnt > 1 && (mode != mode_scan || px_valid || irq_vblank))
                    fail_text("PPU kept running with the LCD switched off");
            end else begin
                off_cnt = 0;
                if (!lcd_q) begin // LCD just switched on, line 0 starts
                    frame_started = 1'b1;
                    lcdc_irqs = 0;
                    scan_entry_cyc = cyc;
                    last_scan_cyc = cyc;
                end
                if (mode == mode_scan && prev_mode != mode_scan) begin
                    if (prev_mode == mode_hblank) begin
                        cur_line++;
                        if (cyc - last_scan_cyc != dots_per_line)
                            fail_value("line period", cyc - last_scan_cyc, dots_per_line);
                    end else begin
                        cur_line = 0;
                        frame_started = 1'b1;
                        lcdc_irqs = 0;
                    end
                    last_scan_cyc = cyc;
                    scan_entry_cyc = cyc;
                end
                if (mode == mode_scan) scan_cnt++;
                if (mode == mode_draw && prev_mode == mode_scan) begin
                    if (scan_cnt != 80) fail_value("scan length", scan_cnt, 80);
                    scan_cnt = 0;
                end
                if (px_valid) begin
                    if (px != expected_px(cur_line, px_cnt))
                        fail_value($sformatf("px line %0d x %0d", cur_line, px_cnt),
                                   px, expected_px(cur_line, px_cnt));
                    px_cnt++;
                end
                if (mode == mode_hblank && prev_mode == mode_draw) begin
                    if (px_cnt != 160)
                        fail_value($sformatf("px_valid count line %0d", cur_line), px_cnt, 160);
                    px_cnt = 0;
                end
                if (irq_lcdc) begin
                    lcdc_irqs++;
                    if (ie_sh == 4'b1000 && (cur_line != lyc_sh || cyc - scan_entry_cyc != 1))
                        fail_text($sformatf("irq_lcdc at line %0d dot %0d, wanted line %0d dot 1",
                                            cur_line, cyc - scan_entry_cyc, lyc_sh));
                end
                if (irq_vblank) begin
                    if (mode != mode_vblank || prev_mode == mode_vblank)
                        fail_text("irq_vblank did not line up with the V-blank entry");
                    if (frame_started && (cur_line != 143 || cyc - last_scan_cyc != 456))
                        fail_text("irq_vblank did not come 144 lines after the frame start");
                    if (have_vb && cyc - last_vb_cyc != 154 * 456)
                        fail_value("irq_vblank period", cyc - last_vb_cyc, 154 * 456);
                    if (frame_started && ie_sh == 4'b1000 && lyc_sh < 144 && lcdc_irqs != 1)
                        fail_value("irq_lcdc per frame", lcdc_irqs, 1);
                    have_vb = 1'b1;
                    last_vb_cyc = cyc;
                    frame_started = 1'b0;
                end
            end
            if (cpu_wr) begin
                case (cpu_addr)
                    16'hFF40: lcdc_sh = cpu_wdata;
                    16'hFF41: ie_sh   = cpu_wdata[6:3];
                    16'hFF42: scy_sh  = cpu_wdata;
                    16'hFF43: scx_sh  = cpu_wdata;
                    16'hFF45: lyc_sh  = cpu_wdata;
                    default: ;
                endcase
            end
            prev_mode = mode;
            lcd_q = lcd_on;
        end
    end

endmodule

// File: bench/ppu_tb.sv
// ########################################
// runs bench/ppu_vectors.txt from the project root
// VRAM byte at A is A[7:0] ^ A[15:8]
// ########################################
module ppu_tb
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       rst;
    cpu_addr_t  cpu_addr;
    logic       cpu_wr;
    logic       cpu_rd;
    reg_byte_t  cpu_wdata;
    reg_byte_t  cpu_rdata;
    logic       vram_rd;
    vram_addr_t vram_addr;
    reg_byte_t  vram_data;
    px_t        px;
    logic       px_valid;
    logic       irq_vblank;
    logic       irq_lcdc;
    ppu_mode_e  mode;
    int         limit = 0;

    ppu_top u_dut (.*);

    ppu_checker u_chk (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // answers one cycle after the read
    always @(posedge clk) begin
        if (vram_rd) begin
            logic [15:0] a;
            a = vram_addr;
            #1 vram_data = a[7:0] ^ a[15:8];
        end
    end

    task automatic write_reg(input cpu_addr_t a, input reg_byte_t d);
        @(posedge clk);
        #1 cpu_addr = a;
        cpu_wdata = d;
        cpu_wr = 1'b1;
        @(posedge clk);
        #1 cpu_wr = 1'b0;
    endtask

    task automatic read_reg(input cpu_addr_t a, input reg_byte_t e);
        u_chk.expect_read(a, e);
        @(posedge clk);
        #1 cpu_addr = a;
        cpu_rd = 1'b1;
        @(posedge clk);
        #1 cpu_rd = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic run_frames(input int n);
        repeat (n) begin
            do begin
                @(posedge clk);
                #1;
            end while (!irq_vblank);
        end
        @(posedge clk);
        #1;
    endtask

    // reads STAT in the draw part of line n, then waits for the line to end
    task automatic check_line(input int n, input reg_byte_t stat_exp);
        do begin
            @(posedge clk);
            #1;
        end while (!(u_chk.cur_line == n && mode == mode_draw));
        u_chk.expect_read(addr_stat, stat_exp);
        cpu_addr = addr_stat;
        cpu_rd = 1'b1;
        @(posedge clk);
        #1 cpu_rd = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (mode != mode_hblank);
        @(posedge clk);
        #1;
    endtask

    // sizes the watchdog from the frame and line commands
    function automatic int count_cycles();
        int    fd;
        int    a;
        int    b;
        int    units;
        string cmd;
        string rest;
        units = 2;
        fd = $fopen("bench/ppu_vectors.txt", "r");
        if (fd == 0) return 10000;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": void'($fgets(rest, fd));
                "W", "R": void'($fscanf(fd, "%h %h", a, b));
                "F": begin
                    void'($fscanf(fd, "%h", a));
                    units += a;
                end
                "L": begin
                    void'($fscanf(fd, "%h %h", a, b));
                    units += 1;
                end
                default: ;
            endcase
        end
        $fclose(fd);
        return units * lines_per_frame * dots_per_line;
    endfunction

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int    fd;
        int    a;
        int    b;
        string cmd;
        string rest;
        rst = 1'b1;
        cpu_addr = '0;
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
        cpu_wdata = '0;
        vram_data = '0;
        limit = count_cycles() + 4000;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        fd = $fopen("bench/ppu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/ppu_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": void'($fgets(rest, fd));
                    "W": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        write_reg(a, b);
                    end
                    "R": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        read_reg(a, b);
                        u_chk.end_test($sformatf("read %h", a[15:0]));
                    end
                    "F": begin
                        void'($fscanf(fd, "%h", a));
                        run_frames(a);
                        u_chk.end_test($sformatf("%0d frames", a));
                    end
                    "L": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        check_line(a, b);
                        u_chk.end_test($sformatf("line %0d", a));
                    end
                    default: u_chk.fail_text($sformatf("unknown command %s in vector file", cmd));
                endcase
            end
            $fclose(fd);
            repeat (dots_per_line) @(posedge clk); // idle with the final register state
            u_chk.end_test("idle tail");
        end
        u_chk.summary();
        if (fd != 0 && u_chk.errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: bench/ppu_vectors.txt
# W addr data | R addr expected | F frames | L line expected-STAT-in-draw
# all numbers hex
R FF46 FF
R FF48 FF
R FF4A FF
R FF41 86
W FF42 13
W FF43 0D
W FF47 E4
R FF47 E4
W FF44 55
R FF44 00
W FF45 05
W FF41 40
R FF41 C2
W FF40 91
L 05 C7
F 2
R FF41 C1
W FF40 89
W FF43 22
F 1
W FF40 90
F 1
W FF40 00
R FF41 C2
R FF44 00

// File: source/ppu_bg_fetcher.sv
// ######################################
// map, low and high reads on back-to-back cycles
// vram_data must be valid one cycle after vram_rd
// ######################################
module ppu_bg_fetcher
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ppu_ctrl_t  ctrl,
    input  line_pos_t  pos,
    input  logic       line_start,
    input  logic       take,
    output logic       vram_rd,
    output vram_addr_t vram_addr,
    input  reg_byte_t  vram_data,
    output tile_row_t  row,
    output logic       row_valid
);

    fetch_state_e state;
    logic [4:0]   col;
    logic [4:0]   col_cur;
    logic         start;
    line_t        ybg;
    vram_addr_t   map_base;
    vram_addr_t   map_addr;
    vram_addr_t   tile_num;
    vram_addr_t   tile_base;
    vram_addr_t   tile_addr;
    vram_addr_t   tile_addr_q;
    reg_byte_t    lo_q;

    assign start   = line_start || (state == f_full && take);
    assign col_cur = line_start ? 5'(ctrl.scx / tile_px) : col;
    assign ybg     = pos.ly + ctrl.scy; // wraps at 256

    always_comb begin
        map_base  = ctrl.map_sel ? map_base_hi : map_base_lo;
        map_addr  = map_base + vram_addr_t'(ybg / tile_px) * vram_addr_t'(map_row_tiles)
                  + vram_addr_t'(col_cur);
        // map byte is on vram_data during f_map
        tile_num  = ctrl.tile_sel ? {8'h00, vram_data} : {{8{vram_data[7]}}, vram_data};
        tile_base = ctrl.tile_sel ? tile_base_unsigned : tile_base_signed;
        tile_addr = tile_base + tile_num * vram_addr_t'(tile_bytes)
                  + vram_addr_t'(2 * (ybg % tile_px));
    end

    always_comb begin
        case (state)
            f_map:   vram_addr = tile_addr;        // low plane
            f_lo:    vram_addr = tile_addr_q + 1'b1; // high plane
            default: vram_addr = map_addr;
        endcase
    end

    assign vram_rd = ctrl.lcd_en && (start || state == f_map || state == f_lo);

    always_ff @(posedge clk) begin
        if (rst || !ctrl.lcd_en) begin
            state     <= f_idle;
            col       <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= 1'b0;
            if (start) begin
                state <= f_map;
                col   <= col_cur + 1'b1; // wraps at 32 tiles
            end else if (pos.mode != mode_draw) begin
                state <= f_idle;
            end else begin
                case (state)
                    f_map: state <= f_lo;
                    f_lo:  state <= f_hi;
                    f_hi: begin
                        state     <= f_full; // hold row until take
                        row_valid <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // bg_en off keeps the timing but stores blank planes
    always_ff @(posedge clk) begin
        if (state == f_map) begin
            tile_addr_q <= tile_addr;
        end
        if (state == f_lo) begin
            lo_q <= ctrl.bg_en ? vram_data : '0;
        end
        if (state == f_hi) begin
            row.hi <= ctrl.bg_en ? vram_data : '0;
            row.lo <= lo_q;
        end
    end

endmodule

// File: source/ppu_line_timer.sv
// ######################################
// one dot per clock while the LCD is on
// held at dot 0, LY 0, scan mode while off
// ######################################
module ppu_line_timer
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ppu_ctrl_t ctrl,
    input  logic      lyc_match,
    input  logic      line_done,
    output line_pos_t pos,
    output logic      line_start,
    output logic      irq_vblank,
    output logic      irq_lcdc
);

    dot_t      dot;
    line_t     ly;
    line_t     ly_next;
    ppu_mode_e mode;
    logic      end_of_line;
    logic      stat_cond;
    logic      stat_q;

    assign pos.ly   = ly;
    assign pos.mode = mode;

    assign end_of_line = (dot == dot_t'(dots_per_line - 1));
    assign ly_next     = (ly == line_t'(lines_per_frame - 1)) ? '0 : ly + 1'b1;

    // V-blank only counts through its own enable bit
    assign stat_cond = ctrl.lcd_en && (
        (ctrl.stat_ie[stat_lyc_ie - stat_hblank_ie] && lyc_match) ||
        (ctrl.stat_ie[0] && mode == mode_hblank) ||
        (ctrl.stat_ie[stat_vblank_ie - stat_hblank_ie] && mode == mode_vblank) ||
        (ctrl.stat_ie[stat_scan_ie - stat_hblank_ie] && mode == mode_scan));

    always_ff @(posedge clk) begin
        if (rst || !ctrl.lcd_en) begin
            dot        <= '0;
            ly         <= '0;
            mode       <= mode_scan;
            line_start <= 1'b0;
            irq_vblank <= 1'b0;
            stat_q     <= 1'b0;
            irq_lcdc   <= 1'b0;
        end else begin
            line_start <= (mode == mode_scan) && (dot == dot_t'(scan_dots - 1)); // first draw dot
            irq_vblank <= end_of_line && (ly == line_t'(visible_lines - 1));
            stat_q     <= stat_cond;
            irq_lcdc   <= stat_cond && !stat_q; // rising edge only
            if (end_of_line) begin
                dot  <= '0;
                ly   <= ly_next;
                mode <= (ly_next >= line_t'(visible_lines)) ? mode_vblank : mode_scan;
            end else begin
                dot <= dot + 1'b1;
                case (mode)
                    mode_scan: if (dot == dot_t'(scan_dots - 1)) mode <= mode_draw;
                    mode_draw: if (line_done) mode <= mode_hblank; // length varies with SCX
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: source/ppu_pixel_shifter.sv
// ######################################
// shifts 160 pixels per line, MSB first
// first SCX mod 8 pixels are dropped
// ######################################
module ppu_pixel_shifter
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ppu_ctrl_t ctrl,
    input  logic      line_start,
    input  tile_row_t row,
    input  logic      row_valid,
    output logic      take,
    output px_t       px,
    output logic      px_valid,
    output logic      line_done
);

    logic [7:0] plane_hi;
    logic [7:0] plane_lo;
    logic [2:0] left;     // pixels left after the current one
    logic [3:0] discard;
    logic [7:0] vis;
    logic       active;
    logic       pend;     // row arrived while still shifting
    logic       done;
    logic       shift_en;
    logic       last_px;
    logic       final_px;

    assign shift_en = active && !done;
    assign last_px  = shift_en && (left == '0);
    assign px_valid = shift_en && (discard == '0) && ctrl.lcd_en;
    assign final_px = px_valid && (vis == 8'(screen_width - 1));
    // no take after the last pixel, so the fetcher stays off the bus in hblank
    assign take     = !done && !final_px
                   && ((!active && row_valid) || (last_px && (pend || row_valid)));
    assign px       = {plane_hi[7], plane_lo[7]};

    always_ff @(posedge clk) begin
        if (rst || !ctrl.lcd_en || line_start) begin
            active    <= 1'b0;
            left      <= '0;
            pend      <= 1'b0;
            done      <= 1'b0;
            vis       <= '0;
            line_done <= 1'b0;
            discard   <= (rst || !ctrl.lcd_en) ? '0 : 4'(ctrl.scx % tile_px);
        end else begin
            line_done <= final_px;
            if (final_px) done <= 1'b1;
            if (px_valid) vis <= vis + 1'b1;
            if (shift_en && discard != '0) discard <= discard - 1'b1;
            if (take) pend <= 1'b0;
            else if (row_valid && !done) pend <= 1'b1;
            if (take) begin
                active <= 1'b1;
                left   <= 3'(tile_px - 1);
            end else if (last_px) begin
                active <= 1'b0; // ran dry
            end else if (shift_en) begin
                left <= left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            plane_hi <= row.hi;
            plane_lo <= row.lo;
        end else if (shift_en) begin
            plane_hi <= {plane_hi[6:0], 1'b0};
            plane_lo <= {plane_lo[6:0], 1'b0};
        end
    end

endmodule

// File: source/ppu_reg_pkg.sv
// ######################################
// LCD register map; all registers reset to zero
// ######################################
package ppu_reg_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  reg_byte_t;

    localparam cpu_addr_t addr_lcdc = 16'hFF40;
    localparam cpu_addr_t addr_stat = 16'hFF41;
    localparam cpu_addr_t addr_scy  = 16'hFF42;
    localparam cpu_addr_t addr_scx  = 16'hFF43;
    localparam cpu_addr_t addr_ly   = 16'hFF44; // read only
    localparam cpu_addr_t addr_lyc  = 16'hFF45;
    localparam cpu_addr_t addr_bgp  = 16'hFF47; // stored, not applied

    localparam int lcdc_bg_en    = 0;
    localparam int lcdc_map_sel  = 3;
    localparam int lcdc_tile_sel = 4;
    localparam int lcdc_lcd_en   = 7;

    localparam int stat_hblank_ie = 3;
    localparam int stat_vblank_ie = 4;
    localparam int stat_scan_ie   = 5;
    localparam int stat_lyc_ie    = 6;

    localparam reg_byte_t unmapped_read = 8'hFF;

    // decoded control seen by the timing and fetch blocks
    typedef struct packed {
        logic       lcd_en;
        logic       bg_en;
        logic       map_sel;
        logic       tile_sel;
        logic [3:0] stat_ie;  // STAT bits 6..3
        reg_byte_t  scx;
        reg_byte_t  scy;
        reg_byte_t  lyc;
    } ppu_ctrl_t;

endpackage

// File: source/ppu_regs.sv
// ######################################
// CPU register file, read data valid one cycle after cpu_rd
// writes to LY and STAT bits 2..0 are dropped
// ######################################
module ppu_regs
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t cpu_addr,
    input  logic      cpu_wr,
    input  logic      cpu_rd,
    input  reg_byte_t cpu_wdata,
    input  line_pos_t pos,
    output reg_byte_t cpu_rdata,
    output ppu_ctrl_t ctrl,
    output logic      lyc_match
);

    reg_byte_t  lcdc;
    logic [3:0] stat_ie;
    reg_byte_t  scy;
    reg_byte_t  scx;
    reg_byte_t  lyc;
    reg_byte_t  bgp;

    assign lyc_match = (pos.ly == lyc); // live coincidence, also STAT bit 2

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= '0;
            stat_ie <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= '0;
        end else if (cpu_wr) begin
            case (cpu_addr)
                addr_lcdc: lcdc    <= cpu_wdata;
                addr_stat: stat_ie <= cpu_wdata[stat_lyc_ie:stat_hblank_ie];
                addr_scy:  scy     <= cpu_wdata;
                addr_scx:  scx     <= cpu_wdata;
                addr_lyc:  lyc     <= cpu_wdata;
                addr_bgp:  bgp     <= cpu_wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_rdata <= '0;
        end else if (cpu_rd) begin
            case (cpu_addr)
                addr_lcdc: cpu_rdata <= lcdc;
                addr_stat: cpu_rdata <= {1'b1, stat_ie, lyc_match, pos.mode};
                addr_scy:  cpu_rdata <= scy;
                addr_scx:  cpu_rdata <= scx;
                addr_ly:   cpu_rdata <= pos.ly;
                addr_lyc:  cpu_rdata <= lyc;
                addr_bgp:  cpu_rdata <= bgp;
                default:   cpu_rdata <= unmapped_read; // DMA, OBPx and window included
            endcase
        end
    end

    always_comb begin
        ctrl.lcd_en   = lcdc[lcdc_lcd_en];
        ctrl.bg_en    = lcdc[lcdc_bg_en];
        ctrl.map_sel  = lcdc[lcdc_map_sel];
        ctrl.tile_sel = lcdc[lcdc_tile_sel];
        ctrl.stat_ie  = stat_ie;
        ctrl.scx      = scx;
        ctrl.scy      = scy;
        ctrl.lyc      = lyc;
    end

endmodule

// File: source/ppu_timing_pkg.sv
// ######################################
// fixed screen geometry, no parameters
// ######################################
package ppu_timing_pkg;

    typedef logic [8:0]  dot_t;        // dot within a line
    typedef logic [7:0]  line_t;       // LY
    typedef logic [1:0]  px_t;         // colour index
    typedef logic [15:0] vram_addr_t;

    localparam int dots_per_line   = 456;
    localparam int scan_dots       = 80;
    localparam int visible_lines   = 144;
    localparam int lines_per_frame = 154;
    localparam int screen_width    = 160;
    localparam int tile_px         = 8;
    localparam int map_row_tiles   = 32;
    localparam int tile_bytes      = 16;

    localparam vram_addr_t map_base_lo        = 16'h9800;
    localparam vram_addr_t map_base_hi        = 16'h9C00;
    localparam vram_addr_t tile_base_unsigned = 16'h8000;
    localparam vram_addr_t tile_base_signed   = 16'h9000; // tile number is signed here

    // encoding is the STAT mode field
    typedef enum logic [1:0] {
        mode_hblank = 2'd0,
        mode_vblank = 2'd1,
        mode_scan   = 2'd2,
        mode_draw   = 2'd3
    } ppu_mode_e;

    typedef enum logic [2:0] {
        f_idle,
        f_map,
        f_lo,
        f_hi,
        f_full
    } fetch_state_e;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } tile_row_t;

    typedef struct packed {
        line_t     ly;
        ppu_mode_e mode;
    } line_pos_t;

endpackage

// File: source/ppu_top.sv
// ######################################
// background-only PPU, no sprites or window
// ######################################
module ppu_top
    import ppu_reg_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cpu_addr_t  cpu_addr,
    input  logic       cpu_wr,
    input  logic       cpu_rd,
    input  reg_byte_t  cpu_wdata,
    output reg_byte_t  cpu_rdata,
    output logic       vram_rd,
    output vram_addr_t vram_addr,
    input  reg_byte_t  vram_data,
    output px_t        px,
    output logic       px_valid,
    output logic       irq_vblank,
    output logic       irq_lcdc,
    output ppu_mode_e  mode
);

    ppu_ctrl_t ctrl;
    line_pos_t pos;
    logic      lyc_match;
    logic      line_start;
    logic      line_done;
    tile_row_t row;
    logic      row_valid;
    logic      take;

    assign mode = pos.mode;

    ppu_regs u_regs (
        .clk(clk), .rst(rst),
        .cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .cpu_wdata(cpu_wdata),
        .pos(pos), .cpu_rdata(cpu_rdata), .ctrl(ctrl), .lyc_match(lyc_match)
    );

    ppu_line_timer u_timer (
        .clk(clk), .rst(rst), .ctrl(ctrl), .lyc_match(lyc_match), .line_done(line_done),
        .pos(pos), .line_start(line_start), .irq_vblank(irq_vblank), .irq_lcdc(irq_lcdc)
    );

    ppu_bg_fetcher u_fetch (
        .clk(clk), .rst(rst), .ctrl(ctrl), .pos(pos), .line_start(line_start), .take(take),
        .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
        .row(row), .row_valid(row_valid)
    );

    ppu_pixel_shifter u_shift (
        .clk(clk), .rst(rst), .ctrl(ctrl), .line_start(line_start),
        .row(row), .row_valid(row_valid), .take(take),
        .px(px), .px_valid(px_valid), .line_done(line_done)
    );

endmodule

// File: src.f
source/ppu_reg_pkg.sv
source/ppu_timing_pkg.sv
source/ppu_regs.sv
source/ppu_line_timer.sv
source/ppu_bg_fetcher.sv
source/ppu_pixel_shifter.sv
source/ppu_top.sv
bench/ppu_checker.sv
bench/ppu_assert.sv
bench/ppu_tb.sv
